//--- include/lane_nav_defines.svh
`ifndef LANE_NAV_DEFINES_SVH
`define LANE_NAV_DEFINES_SVH

// frame geometry, 32x32 grayscale
`define IMG_PIXELS 1024
`define IMG_WIDTH 32

// master sclk half period in clk cycles
`define SPI_HALF_PERIOD 4

// upper bits of the motor command byte
`define CMD_HEADER 5'b10101

// scores strictly above this turn right
`define LANE_THRESHOLD 1024

`endif

//--- src/lane_nav_pkg.sv
package lane_nav_pkg;

    // frame sequencing in the controller
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        RECEIVING  = 3'd1,
        PROCESSING = 3'd2,
        SENDING    = 3'd3,
        DONE       = 3'd4
    } ctrl_state_t;

    // one-hot, low bits of the command byte
    typedef enum logic [2:0] {
        LEFT     = 3'b001,
        RIGHT    = 3'b010,
        STRAIGHT = 3'b100
    } motor_cmd_t;

    // right half sum minus left half sum
    typedef logic signed [47:0] lane_score_t;

endpackage

//--- src/pixel_stream_if.sv
`timescale 1ns/1ps

interface pixel_stream_if;

    logic                      start;
    logic                      valid;
    logic [7:0]                data;
    logic                      score_valid;
    lane_nav_pkg::lane_score_t score;

    // no back-pressure, sink takes every valid
    modport source (
        output start, valid, data,
        input  score_valid, score
    );

    modport sink (
        input  start, valid, data,
        output score_valid, score
    );

endinterface

//--- src/spi_byte_rx.sv
`timescale 1ns/1ps

module spi_byte_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sclk,
    input  logic       ss,
    input  logic       mosi,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic [2:0] sclk_sync;
    logic [2:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       ss_fall;
    logic       sample;
    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;

    // two stages into clk, the third only for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= 3'b000;
            ss_sync   <= 3'b111;
            mosi_sync <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], sclk};
            ss_sync   <= {ss_sync[1:0], ss};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign ss_fall   = ~ss_sync[1] & ss_sync[2];
    // mosi_sync[1] lines up with sclk_sync[1]
    assign sample    = sclk_rise & ~ss_sync[1] & ~ss_fall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (ss_fall) begin
                bit_cnt <= 3'd0;
            end else if (sample) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_reg <= {shift_reg[6:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {shift_reg[6:0], mosi_sync[1]};
            end
        end
    end

    // a byte needs eight sclk edges, so strobes are never adjacent
    assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
        else $error("spi_byte_rx: rx_valid high on consecutive cycles");

endmodule

//--- src/spi_byte_tx.sv
`timescale 1ns/1ps
`include "lane_nav_defines.svh"

module spi_byte_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx_done,
    output logic       sclk,
    output logic       ss,
    output logic       mosi
);

    localparam int DIV_W = $clog2(`SPI_HALF_PERIOD + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;
    logic             phase;
    logic             busy;
    logic             run;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;

    assign half_tick = (div_cnt == DIV_W'(`SPI_HALF_PERIOD - 1));

    // free-running phase, gated onto the pin only while running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            phase   <= 1'b0;
        end else if (half_tick) begin
            div_cnt <= '0;
            phase   <= ~phase;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            run       <= 1'b0;
            ss        <= 1'b1;
            tx_done   <= 1'b0;
            bit_cnt   <= 3'd0;
            shift_reg <= 8'h00;
        end else begin
            tx_done <= 1'b0;
            if (!busy) begin
                if (tx_start) begin
                    busy      <= 1'b1;
                    ss        <= 1'b0;
                    bit_cnt   <= 3'd0;
                    shift_reg <= tx_byte;
                end
            end else if (half_tick && phase) begin
                // phase about to fall
                if (!run) begin
                    // first low half gives msb its setup time
                    run <= 1'b1;
                end else begin
                    shift_reg <= {shift_reg[6:0], 1'b0};
                    bit_cnt   <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        run     <= 1'b0;
                        busy    <= 1'b0;
                        ss      <= 1'b1;
                        tx_done <= 1'b1;
                    end
                end
            end
        end
    end

    assign sclk = run & phase;
    assign mosi = shift_reg[7];

    assert property (@(posedge clk) disable iff (!rst_n) $fell(ss) |-> !ss until tx_done)
        else $error("spi_byte_tx: ss released before the byte finished");

endmodule

//--- src/lane_score_engine.sv
`timescale 1ns/1ps
`include "lane_nav_defines.svh"

module lane_score_engine (
    input logic          clk,
    input logic          rst_n,
    pixel_stream_if.sink pix
);

    localparam int IDX_W    = $clog2(`IMG_PIXELS + 1);
    localparam int HALF_COL = `IMG_WIDTH / 2;
    localparam int SCORE_W  = $bits(lane_nav_pkg::lane_score_t);

    logic [IDX_W-1:0]          idx;
    logic [IDX_W-1:0]          pix_pos;
    logic                      right_col;
    lane_nav_pkg::lane_score_t pix_ext;
    lane_nav_pkg::lane_score_t acc;
    lane_nav_pkg::lane_score_t acc_base;
    lane_nav_pkg::lane_score_t acc_next;

    // start pixel is always pixel 0
    assign pix_pos   = pix.start ? '0 : idx;
    assign right_col = (pix_pos % IDX_W'(`IMG_WIDTH)) >= IDX_W'(HALF_COL);
    assign pix_ext   = {{(SCORE_W - 8){1'b0}}, pix.data};
    assign acc_base  = pix.start ? '0 : acc;
    assign acc_next  = right_col ? acc_base + pix_ext : acc_base - pix_ext;

    // idx parks at the frame limit until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx             <= IDX_W'(`IMG_PIXELS);
            pix.score_valid <= 1'b0;
        end else begin
            pix.score_valid <= pix.valid && (pix_pos == IDX_W'(`IMG_PIXELS - 1));
            if (pix.valid) begin
                idx <= pix_pos + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix.valid) begin
            acc <= acc_next;
        end
    end

    // holds its value from the score_valid cycle until the next start
    assign pix.score = acc;

    assert property (@(posedge clk) disable iff (!rst_n)
        (pix.valid && !pix.start) |-> (idx != IDX_W'(`IMG_PIXELS)))
        else $error("lane_score_engine: pixel beyond frame without start");

endmodule

//--- src/lane_nav_ctrl.sv
`timescale 1ns/1ps
`include "lane_nav_defines.svh"

module lane_nav_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [7:0]     rx_byte,
    input  logic           rx_valid,
    input  logic           test_mode,
    input  logic           test_pixel_valid,
    input  logic [7:0]     test_pixel_data,
    pixel_stream_if.source pix,
    output logic [7:0]     tx_byte,
    output logic           tx_start,
    input  logic           tx_done,
    output logic [3:0]     status_led
);

    localparam int CNT_W = $clog2(`IMG_PIXELS);

    lane_nav_pkg::ctrl_state_t state;
    lane_nav_pkg::ctrl_state_t state_next;
    lane_nav_pkg::motor_cmd_t  cmd;
    lane_nav_pkg::motor_cmd_t  cmd_next;
    logic [CNT_W-1:0]          pix_cnt;
    logic                      in_valid;
    logic [7:0]                in_byte;
    logic                      accept;
    logic                      last_pix;

    // test port replaces spi while test_mode is high
    assign in_valid = test_mode ? test_pixel_valid : rx_valid;
    assign in_byte  = test_mode ? test_pixel_data : rx_byte;

    // bytes outside idle/receiving are dropped
    assign accept   = in_valid &&
                      (state == lane_nav_pkg::IDLE || state == lane_nav_pkg::RECEIVING);
    assign last_pix = in_valid && (state == lane_nav_pkg::RECEIVING) &&
                      (pix_cnt == CNT_W'(`IMG_PIXELS - 1));

    always_comb begin
        state_next = state;
        case (state)
            lane_nav_pkg::IDLE: begin
                if (in_valid) begin
                    state_next = lane_nav_pkg::RECEIVING;
                end
            end
            lane_nav_pkg::RECEIVING: begin
                if (last_pix) begin
                    state_next = lane_nav_pkg::PROCESSING;
                end
            end
            lane_nav_pkg::PROCESSING: begin
                if (pix.score_valid) begin
                    state_next = lane_nav_pkg::SENDING;
                end
            end
            lane_nav_pkg::SENDING: begin
                if (tx_done) begin
                    state_next = lane_nav_pkg::DONE;
                end
            end
            default: begin
                state_next = lane_nav_pkg::IDLE;
            end
        endcase
    end

    // negative goes left, only strictly above threshold goes right
    always_comb begin
        if (pix.score < 0) begin
            cmd_next = lane_nav_pkg::LEFT;
        end else if (pix.score > lane_nav_pkg::lane_score_t'(`LANE_THRESHOLD)) begin
            cmd_next = lane_nav_pkg::RIGHT;
        end else begin
            cmd_next = lane_nav_pkg::STRAIGHT;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lane_nav_pkg::IDLE;
            pix_cnt   <= '0;
            pix.start <= 1'b0;
            pix.valid <= 1'b0;
            cmd       <= lane_nav_pkg::STRAIGHT;
            tx_start  <= 1'b0;
        end else begin
            state     <= state_next;
            pix.valid <= accept;
            pix.start <= accept && (state == lane_nav_pkg::IDLE);
            // one pulse, lands in the first SENDING cycle
            tx_start  <= (state == lane_nav_pkg::PROCESSING) && pix.score_valid;
            if (accept) begin
                pix_cnt <= (state == lane_nav_pkg::IDLE) ? CNT_W'(1) : pix_cnt + 1'b1;
            end
            if ((state == lane_nav_pkg::PROCESSING) && pix.score_valid) begin
                cmd <= cmd_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pix.data <= in_byte;
        end
    end

    assign tx_byte = {`CMD_HEADER, cmd};

    always_comb begin
        case (state)
            lane_nav_pkg::IDLE:       status_led = 4'b0001;
            lane_nav_pkg::RECEIVING:  status_led = 4'b0010;
            lane_nav_pkg::PROCESSING: status_led = 4'b0100;
            lane_nav_pkg::SENDING:    status_led = 4'b1000;
            lane_nav_pkg::DONE:       status_led = 4'b1111;
            default:                  status_led = 4'b0000;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> (state == lane_nav_pkg::SENDING))
        else $error("lane_nav_ctrl: tx_start outside SENDING");

endmodule

//--- src/lane_nav_top.sv
`timescale 1ns/1ps

module lane_nav_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_slave_sclk,
    input  logic       spi_slave_mosi,
    input  logic       spi_slave_ss,
    output logic       spi_master_sclk,
    output logic       spi_master_mosi,
    output logic       spi_master_ss,
    output logic [3:0] status_led,
    input  logic       test_mode,
    input  logic       test_pixel_valid,
    input  logic [7:0] test_pixel_data
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_done;

    pixel_stream_if pix_if ();

    // image bytes from the host
    spi_byte_rx i_spi_byte_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .sclk     (spi_slave_sclk),
        .ss       (spi_slave_ss),
        .mosi     (spi_slave_mosi),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    lane_nav_ctrl i_lane_nav_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_byte          (rx_byte),
        .rx_valid         (rx_valid),
        .test_mode        (test_mode),
        .test_pixel_valid (test_pixel_valid),
        .test_pixel_data  (test_pixel_data),
        .pix              (pix_if.source),
        .tx_byte          (tx_byte),
        .tx_start         (tx_start),
        .tx_done          (tx_done),
        .status_led       (status_led)
    );

    lane_score_engine i_lane_score_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .pix   (pix_if.sink)
    );

    // command byte to the motor board
    spi_byte_tx i_spi_byte_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_done  (tx_done),
        .sclk     (spi_master_sclk),
        .ss       (spi_master_ss),
        .mosi     (spi_master_mosi)
    );

endmodule

//--- tb/lane_nav_tb.sv
`timescale 1ns/1ps
`include "lane_nav_defines.svh"

module lane_nav_tb;

    logic       clk;
    logic       rst_n;
    logic       spi_slave_sclk;
    logic       spi_slave_mosi;
    logic       spi_slave_ss;
    logic       spi_master_sclk;
    logic       spi_master_mosi;
    logic       spi_master_ss;
    logic [3:0] status_led;
    logic       test_mode;
    logic       test_pixel_valid;
    logic [7:0] test_pixel_data;

    logic [7:0] src_q[$];
    logic [7:0] left_q[$];
    logic [7:0] right_q[$];
    logic [7:0] extra_q[$];
    logic [7:0] exp_q[$];
    logic [3:0] led_q[$];
    logic [3:0] led_prev;
    logic [7:0] mon_shift;
    logic [7:0] last_cmd;
    logic       sclk_prev;
    int         mon_bits;
    int         byte_count;

    lane_nav_top i_lane_nav_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .spi_slave_sclk   (spi_slave_sclk),
        .spi_slave_mosi   (spi_slave_mosi),
        .spi_slave_ss     (spi_slave_ss),
        .spi_master_sclk  (spi_master_sclk),
        .spi_master_mosi  (spi_master_mosi),
        .spi_master_ss    (spi_master_ss),
        .status_led       (status_led),
        .test_mode        (test_mode),
        .test_pixel_valid (test_pixel_valid),
        .test_pixel_data  (test_pixel_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    // left half columns carry l and the right half r
    function automatic logic [7:0] pixel_value(input int n, input logic [7:0] l,
                                               input logic [7:0] r);
        return ((n % `IMG_WIDTH) < (`IMG_WIDTH / 2)) ? l : r;
    endfunction

    function automatic logic [7:0] command_for_score(input logic [7:0] l, input logic [7:0] r);
        longint score;
        score = longint'(`IMG_PIXELS / 2) * (longint'(r) - longint'(l));
        if (score < 0) begin
            return {`CMD_HEADER, 3'b001};
        end else if (score > `LANE_THRESHOLD) begin
            return {`CMD_HEADER, 3'b010};
        end
        return {`CMD_HEADER, 3'b100};
    endfunction

    task automatic read_vectors();
        int    fd;
        int    fields;
        int    src;
        int    l;
        int    r;
        int    x;
        int    e;
        string line;
        fd = $fopen("tb/lane_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the test vector file tb/lane_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 1) != "//") begin
                fields = $sscanf(line, "%h %h %h %h %h", src, l, r, x, e);
                if (fields == 5) begin
                    src_q.push_back(src[7:0]);
                    left_q.push_back(l[7:0]);
                    right_q.push_back(r[7:0]);
                    extra_q.push_back(x[7:0]);
                    exp_q.push_back(e[7:0]);
                end
            end
        end
        $fclose(fd);
        if (src_q.size() == 0) begin
            stop_with_failure("the test vector file holds no test lines");
        end
    endtask

    // mode 0 with 8 clk per sclk half period
    task automatic spi_frame(input logic [7:0] l, input logic [7:0] r, input int count);
        logic [7:0] pix_byte;
        @(posedge clk);
        spi_slave_ss <= 1'b0;
        repeat (8) @(posedge clk);
        for (int n = 0; n < count; n++) begin
            pix_byte = pixel_value(n, l, r);
            for (int b = 7; b >= 0; b--) begin
                spi_slave_mosi <= pix_byte[b];
                repeat (8) @(posedge clk);
                spi_slave_sclk <= 1'b1;
                repeat (8) @(posedge clk);
                spi_slave_sclk <= 1'b0;
            end
        end
        repeat (8) @(posedge clk);
        spi_slave_ss <= 1'b1;
    endtask

    task automatic test_port_frame(input logic [7:0] l, input logic [7:0] r);
        int gap;
        for (int n = 0; n < `IMG_PIXELS; n++) begin
            @(posedge clk);
            test_pixel_valid <= 1'b1;
            test_pixel_data  <= pixel_value(n, l, r);
            gap = $urandom % 4;
            if (gap != 0) begin
                @(posedge clk);
                test_pixel_valid <= 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        test_pixel_valid <= 1'b0;
    endtask

    task automatic run_frame(input int idx);
        logic [3:0] led_exp[5] = '{4'b0010, 4'b0100, 4'b1000, 4'b1111, 4'b0001};
        int         start_count;
        check_value("file_cmd", exp_q[idx], command_for_score(left_q[idx], right_q[idx]));
        @(posedge clk);
        test_mode <= src_q[idx][0];
        repeat (4) @(posedge clk);
        led_q.delete();
        start_count = byte_count;
        if (src_q[idx] == 8'h00) begin
            spi_frame(left_q[idx], right_q[idx], `IMG_PIXELS);
        end else begin
            // spi noise alongside that test mode must ignore
            fork
                test_port_frame(left_q[idx], right_q[idx]);
                spi_frame(extra_q[idx], extra_q[idx], 4);
            join
        end
        while (byte_count == start_count) begin
            @(posedge clk);
        end
        while (status_led !== 4'b0001) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        check_value("spi_master_byte", last_cmd, exp_q[idx]);
        check_value("command_count", byte_count - start_count, 1);
        check_value("led_changes", led_q.size(), 5);
        for (int i = 0; i < 5; i++) begin
            check_value("status_led", led_q[i], led_exp[i]);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            led_prev = status_led;
        end else if (status_led !== led_prev) begin
            led_q.push_back(status_led);
            led_prev = status_led;
        end
    end

    // decode the master link on sclk rising while ss is low
    always @(posedge clk) begin
        if (!rst_n) begin
            mon_bits  = 0;
            sclk_prev = 1'b0;
        end else begin
            if (spi_master_ss) begin
                mon_bits = 0;
            end else if (spi_master_sclk && !sclk_prev) begin
                mon_shift = {mon_shift[6:0], spi_master_mosi};
                mon_bits++;
                if (mon_bits == 8) begin
                    last_cmd = mon_shift;
                    byte_count++;
                    mon_bits = 0;
                end
            end
            sclk_prev = spi_master_sclk;
        end
    end

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        stop_with_failure("timeout waiting for motor command");
    endtask

    initial begin
        rst_n            <= 1'b0;
        spi_slave_sclk   <= 1'b0;
        spi_slave_mosi   <= 1'b0;
        spi_slave_ss     <= 1'b1;
        test_mode        <= 1'b0;
        test_pixel_valid <= 1'b0;
        test_pixel_data  <= 8'h00;
        byte_count = 0;
        void'($urandom(32'h1626f4fd));
        read_vectors();
        fork
            watchdog(src_q.size() * `IMG_PIXELS * 200);
        join_none
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // idle state before any frame
        repeat (10) begin
            @(posedge clk);
            check_value("status_led", status_led, 4'b0001);
            check_value("spi_master_ss", spi_master_ss, 1'b1);
            check_value("spi_master_sclk", spi_master_sclk, 1'b0);
        end
        for (int i = 0; i < src_q.size(); i++) begin
            run_frame(i);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
src/lane_nav_pkg.sv
src/pixel_stream_if.sv
src/spi_byte_rx.sv
src/spi_byte_tx.sv
src/lane_score_engine.sv
src/lane_nav_ctrl.sv
src/lane_nav_top.sv
tb/lane_nav_tb.sv

//--- tb/lane_tests.txt
// columns: source (0 spi, 1 test port), left, right, spi noise byte, expected command
// all values hex
0 80 40 00 A9
0 40 43 00 AA
0 55 55 00 AC
0 10 12 00 AC
1 C8 20 5A A9
1 30 33 A5 AA
1 7F 7F FF AC
0 00 FF 00 AA
1 FF 00 3C A9
